// ==== hw/ucache_cfg.svh ====
`ifndef UCACHE_CFG_SVH
`define UCACHE_CFG_SVH

`define UC_NUM_PORT     2
`define UC_NUM_BANK     2
`define UC_NUM_SET      8
`define UC_NUM_WAY      2

`define UC_ADDR_W       32
`define UC_DATA_W       32
`define UC_QUEUE_DEPTH  4

`define UC_PORT_W       1
`define UC_WAY_W        1

// address layout, lowest field first
`define UC_OFFSET_W     2
`define UC_BANK_W       1
`define UC_INDEX_W      3

`define UC_BANK_LO      `UC_OFFSET_W
`define UC_INDEX_LO     (`UC_BANK_LO + `UC_BANK_W)
`define UC_TAG_LO       (`UC_INDEX_LO + `UC_INDEX_W)
`define UC_TAG_W        (`UC_ADDR_W - `UC_TAG_LO)

`endif

// ==== hw/ucache_pkg.sv ====
`include "ucache_cfg.svh"

package ucache_pkg;

    typedef logic [`UC_ADDR_W-1:0]  addr_t;
    typedef logic [`UC_DATA_W-1:0]  data_t;
    typedef logic [`UC_PORT_W-1:0]  port_id_t;
    typedef logic [`UC_BANK_W-1:0]  bank_id_t;
    typedef logic [`UC_INDEX_W-1:0] set_idx_t;
    typedef logic [`UC_TAG_W-1:0]   tag_t;
    typedef logic [`UC_WAY_W-1:0]   way_t;

    // request and return packet, valid travels inside
    typedef struct packed {
        logic     valid;
        logic     is_write;
        port_id_t port;
        addr_t    addr;
        data_t    data;
    } req_pkt_t;

    // writeback, fetch and refill packet
    typedef struct packed {
        logic     valid;
        logic     is_write;
        addr_t    addr;
        data_t    data;
    } mem_pkt_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH_REQ,
        FETCH_WAIT,
        RESPOND
    } bank_state_t;

endpackage

// ==== hw/packet_fifo.sv ====
`timescale 1ns/1ps

module packet_fifo
    import ucache_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic     clk_in,
    input  logic     rst_n,
    input  req_pkt_t in_pkt,
    output logic     in_ack,
    output req_pkt_t out_pkt,
    input  logic     out_ack,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    req_pkt_t         entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign full   = (count == CNT_W'(DEPTH));
    assign in_ack = in_pkt.valid && !full;
    assign push   = in_ack;
    assign pop    = out_ack && out_pkt.valid;

    // head is only valid while something is stored
    always_comb
    begin
        out_pkt       = entries[rd_ptr];
        out_pkt.valid = (count != '0);
    end

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (push)
            entries[wr_ptr] <= in_pkt;
    end

endmodule

// ==== hw/packet_arbiter.sv ====
`timescale 1ns/1ps

module packet_arbiter
    import ucache_pkg::*;
#(
    parameter int  NUM_REQ = 2,
    parameter type pkt_t   = req_pkt_t
)
(
    input  logic               clk_in,
    input  logic               rst_n,
    input  pkt_t               in_pkts [NUM_REQ],
    input  logic [NUM_REQ-1:0] in_valid_mask,
    output logic [NUM_REQ-1:0] in_ack,
    output pkt_t               out_pkt,
    input  logic               out_ack
);

    localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

    logic [NUM_REQ-1:0] req_vec;
    logic [IDX_W-1:0]   ptr;
    logic [IDX_W-1:0]   grant;
    logic [IDX_W-1:0]   lock_idx;
    logic               locked;
    logic               granted;

    always_comb
    begin
        for (int i = 0; i < NUM_REQ; i++)
            req_vec[i] = in_pkts[i].valid && in_valid_mask[i];

        // a held grant wins until its packet is taken
        grant   = locked ? lock_idx : ptr;
        granted = locked;
        if (!locked)
        begin
            for (int k = 0; k < NUM_REQ; k++)
            begin
                if (!granted && req_vec[(int'(ptr) + k) % NUM_REQ])
                begin
                    grant   = IDX_W'((int'(ptr) + k) % NUM_REQ);
                    granted = 1'b1;
                end
            end
        end

        in_ack        = '0;
        in_ack[grant] = granted && out_ack;
        out_pkt       = in_pkts[grant];
        out_pkt.valid = granted;
    end

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            ptr      <= '0;
            lock_idx <= '0;
            locked   <= 1'b0;
        end
        else if (granted && out_ack)
        begin
            locked <= 1'b0;
            ptr    <= (int'(grant) == NUM_REQ - 1) ? '0 : grant + 1'b1;
        end
        else if (granted)
        begin
            locked   <= 1'b1;
            lock_idx <= grant;
        end
    end

endmodule

// ==== hw/bank_store.sv ====
`timescale 1ns/1ps
`include "ucache_cfg.svh"

module bank_store
    import ucache_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_n,
    input  set_idx_t idx,
    input  tag_t     tag,
    output logic     hit,
    output way_t     hit_way,
    output data_t    rd_data,
    output way_t     victim_way,
    output logic     victim_dirty,
    output tag_t     victim_tag,
    output data_t    victim_data,
    input  logic     wr_en,
    input  way_t     wr_way,
    input  data_t    wr_data,
    input  logic     wr_dirty
);

    logic [`UC_NUM_WAY-1:0] valid_arr  [`UC_NUM_SET];
    logic [`UC_NUM_WAY-1:0] dirty_arr  [`UC_NUM_SET];
    way_t                   victim_ptr [`UC_NUM_SET];
    tag_t                   tag_arr    [`UC_NUM_SET][`UC_NUM_WAY];
    data_t                  data_arr   [`UC_NUM_SET][`UC_NUM_WAY];
    logic                   has_free;
    way_t                   free_way;

    // tag compare across the ways
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `UC_NUM_WAY; w++)
        begin
            if (valid_arr[idx][w] && tag_arr[idx][w] == tag)
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
        rd_data = data_arr[idx][hit_way];
    end

    // invalid way first, else the rotating pointer
    always_comb
    begin
        has_free = 1'b0;
        free_way = '0;
        for (int w = 0; w < `UC_NUM_WAY; w++)
        begin
            if (!has_free && !valid_arr[idx][w])
            begin
                has_free = 1'b1;
                free_way = way_t'(w);
            end
        end
        victim_way   = has_free ? free_way : victim_ptr[idx];
        victim_dirty = valid_arr[idx][victim_way] && dirty_arr[idx][victim_way];
        victim_tag   = tag_arr[idx][victim_way];
        victim_data  = data_arr[idx][victim_way];
    end

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < `UC_NUM_SET; s++)
            begin
                valid_arr[s]  <= '0;
                dirty_arr[s]  <= '0;
                victim_ptr[s] <= '0;
            end
        end
        else if (wr_en)
        begin
            valid_arr[idx][wr_way] <= 1'b1;
            dirty_arr[idx][wr_way] <= wr_dirty;
            // a write without a hit is a fill
            if (!hit)
                victim_ptr[idx] <= (victim_ptr[idx] == way_t'(`UC_NUM_WAY - 1)) ?
                                   '0 : victim_ptr[idx] + 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (wr_en)
        begin
            tag_arr[idx][wr_way]  <= tag;
            data_arr[idx][wr_way] <= wr_data;
        end
    end

endmodule

// ==== hw/bank_ctrl.sv ====
`timescale 1ns/1ps
`include "ucache_cfg.svh"

module bank_ctrl
    import ucache_pkg::*;
#(
    parameter int BANK_ID = 0
)
(
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  req_pkt_t                req [`UC_NUM_PORT],
    output logic [`UC_NUM_PORT-1:0] req_ack,
    input  logic [`UC_NUM_PORT-1:0] critical,
    output mem_pkt_t                mem_req,
    input  logic                    mem_req_ack,
    input  mem_pkt_t                mem_rsp,
    output logic                    mem_rsp_ack,
    output req_pkt_t                rsp,
    input  logic                    rsp_ack
);

    bank_state_t             state;
    bank_state_t             state_nxt;
    req_pkt_t                cur;
    data_t                   rd_q;
    port_id_t                last_port;
    port_id_t                pick;
    logic                    pick_valid;
    logic [`UC_NUM_PORT-1:0] cand;
    set_idx_t                cur_idx;
    tag_t                    cur_tag;
    addr_t                   fetch_addr;
    addr_t                   wb_addr;
    logic                    fetch_match;

    logic                    hit;
    way_t                    hit_way;
    data_t                   rd_data;
    way_t                    victim_way;
    logic                    victim_dirty;
    tag_t                    victim_tag;
    data_t                   victim_data;
    logic                    wr_en;
    way_t                    wr_way;
    data_t                   wr_data;
    logic                    wr_dirty;

    assign cur_idx    = cur.addr[`UC_INDEX_LO +: `UC_INDEX_W];
    assign cur_tag    = cur.addr[`UC_TAG_LO +: `UC_TAG_W];
    assign fetch_addr = {cur_tag, cur_idx, bank_id_t'(BANK_ID), {`UC_OFFSET_W{1'b0}}};
    assign wb_addr    = {victim_tag, cur_idx, bank_id_t'(BANK_ID), {`UC_OFFSET_W{1'b0}}};
    assign fetch_match = (state == FETCH_WAIT) && mem_rsp.valid &&
        (mem_rsp.addr[`UC_ADDR_W-1:`UC_OFFSET_W] == fetch_addr[`UC_ADDR_W-1:`UC_OFFSET_W]);

    bank_store store
    (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .idx          (cur_idx),
        .tag          (cur_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_data      (rd_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_data      (wr_data),
        .wr_dirty     (wr_dirty)
    );

    // full queues first, then rotate past the last winner
    always_comb
    begin
        for (int p = 0; p < `UC_NUM_PORT; p++)
            cand[p] = req[p].valid;
        if ((cand & critical) != '0)
            cand = cand & critical;
        pick       = last_port;
        pick_valid = 1'b0;
        for (int k = 1; k <= `UC_NUM_PORT; k++)
        begin
            if (!pick_valid && cand[(int'(last_port) + k) % `UC_NUM_PORT])
            begin
                pick       = port_id_t'((int'(last_port) + k) % `UC_NUM_PORT);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb
    begin
        req_ack     = '0;
        mem_req     = '0;
        rsp         = '0;
        mem_rsp_ack = fetch_match;
        if (state == IDLE)
            req_ack[pick] = pick_valid;
        if (state == WRITEBACK)
        begin
            mem_req.valid    = 1'b1;
            mem_req.is_write = 1'b1;
            mem_req.addr     = wb_addr;
            mem_req.data     = victim_data;
        end
        if (state == FETCH_REQ)
        begin
            mem_req.valid = 1'b1;
            mem_req.addr  = fetch_addr;
        end
        if (state == RESPOND)
        begin
            rsp       = cur;
            rsp.valid = 1'b1;
            rsp.data  = cur.is_write ? cur.data : rd_q;
        end
    end

    always_comb
    begin
        state_nxt = state;
        wr_en     = 1'b0;
        wr_way    = victim_way;
        wr_data   = cur.data;
        wr_dirty  = 1'b1;
        case (state)
            IDLE:
                if (pick_valid)
                    state_nxt = LOOKUP;
            LOOKUP:
                if (hit)
                begin
                    wr_en     = cur.is_write;
                    wr_way    = hit_way;
                    state_nxt = RESPOND;
                end
                else if (victim_dirty)
                    state_nxt = WRITEBACK;
                else if (cur.is_write)
                begin
                    wr_en     = 1'b1;
                    state_nxt = RESPOND;
                end
                else
                    state_nxt = FETCH_REQ;
            WRITEBACK:
                if (mem_req_ack)
                begin
                    // write miss allocates without a fetch
                    wr_en     = cur.is_write;
                    state_nxt = cur.is_write ? RESPOND : FETCH_REQ;
                end
            FETCH_REQ:
                if (mem_req_ack)
                    state_nxt = FETCH_WAIT;
            FETCH_WAIT:
                if (fetch_match)
                begin
                    wr_en     = 1'b1;
                    wr_data   = mem_rsp.data;
                    wr_dirty  = 1'b0;
                    state_nxt = RESPOND;
                end
            RESPOND:
                if (rsp_ack)
                    state_nxt = IDLE;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            last_port <= port_id_t'(`UC_NUM_PORT - 1);
        end
        else
        begin
            state <= state_nxt;
            if (state == IDLE && pick_valid)
                last_port <= pick;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (state == IDLE && pick_valid)
            cur <= req[pick];
        if (state == LOOKUP && hit)
            rd_q <= rd_data;
        if (fetch_match)
            rd_q <= mem_rsp.data;
    end

endmodule

// ==== hw/unified_cache.sv ====
`timescale 1ns/1ps
`include "ucache_cfg.svh"

module unified_cache
    import ucache_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  req_pkt_t                req [`UC_NUM_PORT],
    output logic [`UC_NUM_PORT-1:0] req_ack,
    output req_pkt_t                rsp [`UC_NUM_PORT],
    input  logic [`UC_NUM_PORT-1:0] rsp_ack,
    output mem_pkt_t                mem_req,
    input  logic                    mem_req_ack,
    input  mem_pkt_t                mem_rsp,
    output logic                    mem_rsp_ack
);

    req_pkt_t                head         [`UC_NUM_PORT];
    logic [`UC_NUM_PORT-1:0] head_ack;
    logic [`UC_NUM_PORT-1:0] q_full;

    req_pkt_t                bank_req     [`UC_NUM_BANK][`UC_NUM_PORT];
    logic [`UC_NUM_PORT-1:0] bank_req_ack [`UC_NUM_BANK];
    mem_pkt_t                bank_mem_req [`UC_NUM_BANK];
    logic [`UC_NUM_BANK-1:0] bank_mem_req_ack;
    mem_pkt_t                bank_mem_rsp [`UC_NUM_BANK];
    logic [`UC_NUM_BANK-1:0] bank_mem_rsp_ack;
    req_pkt_t                bank_rsp     [`UC_NUM_BANK];
    logic [`UC_NUM_BANK-1:0] bank_rsp_ack;

    logic [`UC_NUM_BANK-1:0] rsp_mask     [`UC_NUM_PORT];
    logic [`UC_NUM_BANK-1:0] rsp_arb_ack  [`UC_NUM_PORT];

    function automatic bank_id_t bank_of(input addr_t addr);
        return addr[`UC_BANK_LO +: `UC_BANK_W];
    endfunction

    // each head and each refill is shown only to its own bank
    always_comb
    begin
        for (int b = 0; b < `UC_NUM_BANK; b++)
        begin
            for (int p = 0; p < `UC_NUM_PORT; p++)
            begin
                bank_req[b][p]       = head[p];
                bank_req[b][p].valid = head[p].valid && (bank_of(head[p].addr) == bank_id_t'(b));
            end
            bank_mem_rsp[b]       = mem_rsp;
            bank_mem_rsp[b].valid = mem_rsp.valid && (bank_of(mem_rsp.addr) == bank_id_t'(b));
        end
    end

    always_comb
    begin
        for (int p = 0; p < `UC_NUM_PORT; p++)
            for (int b = 0; b < `UC_NUM_BANK; b++)
                rsp_mask[p][b] = (bank_rsp[b].port == port_id_t'(p));
    end

    always_comb
    begin
        head_ack     = '0;
        bank_rsp_ack = '0;
        for (int p = 0; p < `UC_NUM_PORT; p++)
        begin
            for (int b = 0; b < `UC_NUM_BANK; b++)
            begin
                head_ack[p]     = head_ack[p] | bank_req_ack[b][p];
                bank_rsp_ack[b] = bank_rsp_ack[b] | rsp_arb_ack[p][b];
            end
        end
    end

    assign mem_rsp_ack = |bank_mem_rsp_ack;

    for (genvar p = 0; p < `UC_NUM_PORT; p++)
    begin : g_port
        packet_fifo #(.DEPTH(`UC_QUEUE_DEPTH)) input_queue
        (
            .clk_in  (clk_in),
            .rst_n   (rst_n),
            .in_pkt  (req[p]),
            .in_ack  (req_ack[p]),
            .out_pkt (head[p]),
            .out_ack (head_ack[p]),
            .full    (q_full[p])
        );

        packet_arbiter #(.NUM_REQ(`UC_NUM_BANK), .pkt_t(req_pkt_t)) return_arb
        (
            .clk_in        (clk_in),
            .rst_n         (rst_n),
            .in_pkts       (bank_rsp),
            .in_valid_mask (rsp_mask[p]),
            .in_ack        (rsp_arb_ack[p]),
            .out_pkt       (rsp[p]),
            .out_ack       (rsp_ack[p])
        );
    end

    for (genvar b = 0; b < `UC_NUM_BANK; b++)
    begin : g_bank
        bank_ctrl #(.BANK_ID(b)) bank
        (
            .clk_in      (clk_in),
            .rst_n       (rst_n),
            .req         (bank_req[b]),
            .req_ack     (bank_req_ack[b]),
            .critical    (q_full),
            .mem_req     (bank_mem_req[b]),
            .mem_req_ack (bank_mem_req_ack[b]),
            .mem_rsp     (bank_mem_rsp[b]),
            .mem_rsp_ack (bank_mem_rsp_ack[b]),
            .rsp         (bank_rsp[b]),
            .rsp_ack     (bank_rsp_ack[b])
        );
    end

    // writebacks and fetches share the one memory port
    packet_arbiter #(.NUM_REQ(`UC_NUM_BANK), .pkt_t(mem_pkt_t)) mem_arb
    (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .in_pkts       (bank_mem_req),
        .in_valid_mask ({`UC_NUM_BANK{1'b1}}),
        .in_ack        (bank_mem_req_ack),
        .out_pkt       (mem_req),
        .out_ack       (mem_req_ack)
    );

endmodule

// ==== tb/ucache_model.svh ====
`ifndef UCACHE_MODEL_SVH
`define UCACHE_MODEL_SVH

// unwritten words read as address xor this key
localparam logic [31:0] FILL_KEY = 32'h5a5a_c3c3;

// contents in issue order, used for read data
data_t    issued_mem [addr_t];
// contents as of the last answered write, used for writebacks
data_t    done_mem [addr_t];
// what the memory side holds
data_t    backing_mem [addr_t];
req_pkt_t expect_q [`UC_NUM_PORT][$];
int       writebacks;

function automatic data_t fill_word(input addr_t addr);
    return addr ^ FILL_KEY;
endfunction

function automatic data_t model_read(input addr_t addr);
    if (issued_mem.exists(addr))
        return issued_mem[addr];
    return fill_word(addr);
endfunction

function automatic data_t backing_read(input addr_t addr);
    if (backing_mem.exists(addr))
        return backing_mem[addr];
    return fill_word(addr);
endfunction

// three tags per port over two sets in both banks
function automatic addr_t pool_addr(input int port, input int pick);
    tag_t     tag;
    set_idx_t idx;
    bank_id_t bank;
    tag  = tag_t'(port + 2 * (pick % 3));
    idx  = set_idx_t'((pick / 3) % 2);
    bank = bank_id_t'((pick / 6) % 2);
    return {tag, idx, bank, {`UC_OFFSET_W{1'b0}}};
endfunction

task automatic note_accepted(input req_pkt_t pkt);
    req_pkt_t exp;
    exp = pkt;
    if (pkt.is_write)
        issued_mem[pkt.addr] = pkt.data;
    else
        exp.data = model_read(pkt.addr);
    expect_q[pkt.port].push_back(exp);
endtask

task automatic note_writeback(input mem_pkt_t pkt);
    if (!done_mem.exists(pkt.addr))
        stop_run($sformatf("writeback of address %h that was never written", pkt.addr));
    else
    begin
        check_value("writeback data", done_mem[pkt.addr], pkt.data);
        backing_mem[pkt.addr] = pkt.data;
        writebacks++;
    end
endtask

`endif

// ==== tb/tb_unified_cache.sv ====
`timescale 1ns/1ps
`include "ucache_cfg.svh"

module tb_unified_cache
    import ucache_pkg::*;
();

    localparam int PORTS       = `UC_NUM_PORT;
    localparam int RANDOM_REQS = 80;
    localparam int BURST_REQS  = 12;
    localparam int TOTAL_REQS  = PORTS * (RANDOM_REQS + BURST_REQS);
    localparam int STALL_LIMIT = 12;

    logic             clk_in;
    logic             rst_n;
    req_pkt_t         req [PORTS];
    logic [PORTS-1:0] req_ack;
    req_pkt_t         rsp [PORTS];
    logic [PORTS-1:0] rsp_ack;
    mem_pkt_t         mem_req;
    logic             mem_req_ack;
    mem_pkt_t         mem_rsp;
    logic             mem_rsp_ack;

    int               seed;
    int               issued [PORTS];
    int               limit [PORTS];
    int               stall [PORTS];
    logic [PORTS-1:0] taken;
    logic [PORTS-1:0] drop_seen;
    logic             burst;
    logic             hold_rsp;
    logic             rsp_done;
    addr_t            fetch_q [$];
    int               fetch_wait;

    `include "ucache_model.svh"

    unified_cache uut
    (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .req         (req),
        .req_ack     (req_ack),
        .rsp         (rsp),
        .rsp_ack     (rsp_ack),
        .mem_req     (mem_req),
        .mem_req_ack (mem_req_ack),
        .mem_rsp     (mem_rsp),
        .mem_rsp_ack (mem_rsp_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic make_request(input int p);
        req[p].valid    = 1'b1;
        req[p].is_write = (($random(seed) & 1) != 0);
        req[p].port     = port_id_t'(p);
        req[p].addr     = pool_addr(p, int'($unsigned($random(seed)) % 12));
        req[p].data     = $random(seed);
        issued[p]++;
    endtask

    // same address means same bank, so the oldest match is the one answered
    task automatic match_response(input int port, input req_pkt_t got);
        int slot;
        slot = -1;
        for (int i = 0; i < expect_q[port].size(); i++)
            if (slot < 0 && expect_q[port][i].addr == got.addr)
                slot = i;
        if (slot < 0)
            stop_run($sformatf("port %0d got a response for %h with nothing outstanding",
                               port, got.addr));
        else
        begin
            check_value("write flag", 32'(expect_q[port][slot].is_write), 32'(got.is_write));
            check_value("response data", expect_q[port][slot].data, got.data);
            if (got.is_write)
                done_mem[got.addr] = got.data;
            expect_q[port].delete(slot);
        end
    endtask

    task automatic drive_inputs();
        for (int p = 0; p < PORTS; p++)
        begin
            if (taken[p])
            begin
                req[p].valid = 1'b0;
                taken[p]     = 1'b0;
            end
            if (!req[p].valid && issued[p] < limit[p] && (burst || expect_q[p].size() == 0))
                make_request(p);
            rsp_ack[p] = !hold_rsp && rsp[p].valid && (($random(seed) & 3) != 0);
        end
        mem_req_ack = mem_req.valid && (($random(seed) & 3) != 0);
        if (rsp_done)
        begin
            mem_rsp  = '0;
            rsp_done = 1'b0;
        end
        if (!mem_rsp.valid && fetch_q.size() > 0)
        begin
            if (fetch_wait > 0)
                fetch_wait--;
            else
            begin
                mem_rsp.valid    = 1'b1;
                mem_rsp.is_write = 1'b0;
                mem_rsp.addr     = fetch_q[0];
                mem_rsp.data     = backing_read(fetch_q[0]);
            end
        end
    endtask

    task automatic sample_outputs();
        for (int p = 0; p < PORTS; p++)
        begin
            if (req[p].valid && req_ack[p])
            begin
                note_accepted(req[p]);
                taken[p] = 1'b1;
                stall[p] = 0;
            end
            else if (req[p].valid && hold_rsp)
            begin
                stall[p]++;
                if (stall[p] >= STALL_LIMIT)
                    drop_seen[p] = 1'b1;
            end
            if (rsp[p].valid)
                check_value("response port", 32'(p), 32'(rsp[p].port));
            if (rsp[p].valid && rsp_ack[p])
                match_response(p, rsp[p]);
        end
        if (mem_req.valid && mem_req_ack)
        begin
            if (mem_req.is_write)
                note_writeback(mem_req);
            else
            begin
                if (fetch_q.size() == 0)
                    fetch_wait = int'($unsigned($random(seed)) % 6);
                fetch_q.push_back(mem_req.addr);
            end
        end
        if (mem_rsp.valid && mem_rsp_ack)
        begin
            void'(fetch_q.pop_front());
            rsp_done   = 1'b1;
            fetch_wait = int'($unsigned($random(seed)) % 6);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_in);
        #1;
        drive_inputs();
        @(negedge clk_in);
        sample_outputs();
    endtask

    function automatic logic all_done();
        logic done;
        done = (fetch_q.size() == 0) && !mem_rsp.valid;
        for (int p = 0; p < PORTS; p++)
            if (issued[p] < limit[p] || req[p].valid || expect_q[p].size() != 0)
                done = 1'b0;
        return done;
    endfunction

    initial
    begin : main_sequence
        seed        = 51949;
        rst_n       = 1'b0;
        rsp_ack     = '0;
        mem_req_ack = 1'b0;
        mem_rsp     = '0;
        taken       = '0;
        drop_seen   = '0;
        burst       = 1'b0;
        hold_rsp    = 1'b0;
        rsp_done    = 1'b0;
        fetch_wait  = 0;
        writebacks  = 0;
        for (int p = 0; p < PORTS; p++)
        begin
            req[p]    = '0;
            issued[p] = 0;
            limit[p]  = 0;
            stall[p]  = 0;
        end
        repeat (3) @(posedge clk_in);
        #1;
        rst_n = 1'b1;

        // random mix, one request open per port
        for (int p = 0; p < PORTS; p++)
            limit[p] = RANDOM_REQS;
        while (!all_done())
            step_cycle();

        // responses held back until both queues stop accepting
        for (int p = 0; p < PORTS; p++)
            limit[p] = RANDOM_REQS + BURST_REQS;
        burst    = 1'b1;
        hold_rsp = 1'b1;
        while (drop_seen != '1)
            step_cycle();
        hold_rsp = 1'b0;
        while (!all_done())
            step_cycle();

        check_value("writebacks seen", 32'd1, 32'(writebacks > 0));
        $display("Test passed");
        $finish;
    end

    initial
    begin : watchdog
        repeat (TOTAL_REQS * 200) @(posedge clk_in);
        $display("watchdog expired after %0d cycles with requests still open",
                 TOTAL_REQS * 200);
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

endmodule

// ==== all.f ====
+incdir+hw
+incdir+tb
hw/ucache_pkg.sv
hw/packet_fifo.sv
hw/packet_arbiter.sv
hw/bank_store.sv
hw/bank_ctrl.sv
hw/unified_cache.sv
tb/tb_unified_cache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_unified_cache \
    -f all.f -o tb_unified_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_unified_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0
